//--- tb/aib_testdata.hex
// header: vector count, user pattern count
// vectors: data_in, control nibble {itxen, irxen[2:0]}, expected data_out
10 05
0123456789 9 0123456789
fedcba9876 9 fedcba9876
aaaaaaaaaa 9 aaaaaaaaaa
5555555555 9 5555555555
ffffffffff 9 ffffffffff
0000000001 9 0000000001
8000000000 9 8000000000
3c3c3c3c3c 1 0000000000 // itxen low
c3c3c3c3c3 8 0000000000 // irxen 000
123abc4def 9 123abc4def
0f0f0f0f0f a 0000000000 // irxen 010
f0f0f0f0f0 f 0000000000 // irxen 111
9876543210 9 9876543210
5a5aa5a5c3 b 0000000000 // irxen 011
1357924680 9 1357924680
00000fffff 9 00000fffff
// user patterns: external_cntl, 11 bits
555
2aa
7ff
001
400

//--- files.f
hdl/aib_pkg.sv
hdl/aib_tx_split.sv
hdl/aib_sr_serializer.sv
hdl/aib_sr_deserializer.sv
hdl/aib_link_ctrl.sv
hdl/aib_rx_merge.sv
hdl/aib_channel_top.sv
tb/aib_channel_tb.sv

//--- Bender.yml
package:
  name: aib_channel

sources:
  - hdl/aib_pkg.sv
  - hdl/aib_tx_split.sv
  - hdl/aib_sr_serializer.sv
  - hdl/aib_sr_deserializer.sv
  - hdl/aib_link_ctrl.sv
  - hdl/aib_rx_merge.sv
  - hdl/aib_channel_top.sv
  - target: simulation
    files:
      - tb/aib_channel_tb.sv

# top levels: aib_channel_top (design), aib_channel_tb (simulation)
# stimulus file read at run time: tb/aib_testdata.hex

//--- tb/aib_channel_tb.sv
`timescale 1ns/1ps

module aib_channel_tb;

    localparam int CLK_PERIOD = 20;
    localparam int FRAME      = aib_pkg::SR_LEN + 1;
    localparam int LINK_BOUND = 4 * FRAME + aib_pkg::CAL_CYCLES;
    localparam int N_RAND     = 12;   // lfsr words per loopback run

    logic                          clk = 1'b0;
    logic                          rst_n;
    aib_pkg::word_t                data_in;
    logic                          itxen;
    logic [2:0]                    irxen;
    aib_pkg::word_t                data_out;
    logic                          config_done;
    logic                          tx_lock_req;
    logic                          rx_lock_req;
    logic                          adapter_rstn;
    logic                          mac_rdy;
    logic [aib_pkg::USER_BITS-1:0] external_cntl;
    aib_pkg::pad_word_t            pad_loop;       // pad_tx wired back to pad_rx
    logic                          sr_data_loop;
    logic                          sr_load_loop;
    logic                          tx_transfer_en;
    logic                          rx_transfer_en;
    logic                          fs_mac_rdy;
    aib_pkg::sr_word_t             sr_tomac;

    aib_pkg::word_t tdata [0:63];   // testdata image
    int             n_vec;
    int             n_user;
    int             error_count = 0;
    int             check_count = 0;
    longint         wd_ns = 0;
    logic [31:0]    lfsr_state = 32'hfc7e2736;

    // stage 1 holds the word now on the pads
    logic           s1_valid = 1'b0;
    logic           s1_tx;
    logic [2:0]     s1_rx;
    aib_pkg::word_t s1_data;
    aib_pkg::word_t s1_exp;
    string          s1_name;
    // stage 2 holds the word now due at data_out
    logic           s2_valid = 1'b0;
    aib_pkg::word_t s2_exp;
    string          s2_name;

    always #(CLK_PERIOD/2) clk = ~clk;

    aib_channel_top dut (
        .m_ns_fwd_clk        (clk),
        .rst_n               (rst_n),
        .data_in             (data_in),
        .itxen               (itxen),
        .irxen               (irxen),
        .data_out            (data_out),
        .config_done         (config_done),
        .tx_dcc_dll_lock_req (tx_lock_req),
        .rx_dcc_dll_lock_req (rx_lock_req),
        .ns_adapter_rstn     (adapter_rstn),
        .ns_mac_rdy          (mac_rdy),
        .external_cntl       (external_cntl),
        .pad_tx              (pad_loop),
        .pad_rx              (pad_loop),
        .ns_sr_data          (sr_data_loop),
        .ns_sr_load          (sr_load_loop),
        .fs_sr_data          (sr_data_loop),
        .fs_sr_load          (sr_load_loop),
        .tx_transfer_en      (tx_transfer_en),
        .rx_transfer_en      (rx_transfer_en),
        .fs_mac_rdy          (fs_mac_rdy),
        .sr_tomac            (sr_tomac)
    );

    // ==================================================
    // helpers
    // ==================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic random_word(output aib_pkg::word_t w);
        for (int i = 0; i < $bits(aib_pkg::word_t); i++) begin
            lfsr_state = lfsr_next(lfsr_state);   // one step per bit
            w[i]       = lfsr_state[0];
        end
    endtask

    // even word bits land on half 0 and odd ones on half 1
    function automatic aib_pkg::pad_word_t split_pads(input aib_pkg::word_t w);
        aib_pkg::pad_word_t p;
        for (int j = 0; j < $bits(aib_pkg::word_t); j++) begin
            if (j % 2 == 0) p.dat0[j/2] = w[j];
            else            p.dat1[j/2] = w[j];
        end
        return p;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // checks what is due and drives the next vector for one cycle
    task automatic data_step(input logic valid, input aib_pkg::word_t d, input logic tx,
                             input logic [2:0] rx, input aib_pkg::word_t e, input string name);
        aib_pkg::pad_word_t pe;
        @(negedge clk);
        if (s2_valid) check_value({s2_name, " data_out"}, s2_exp, data_out);
        pe = '0;
        if (s1_valid && s1_tx) pe = split_pads(s1_data);
        if (s1_valid) check_value({s1_name, " pad_tx"}, pe, pad_loop);
        irxen    = s1_valid ? s1_rx : aib_pkg::RXEN_SYNC;   // rx gate meets its own pad word
        s2_valid = s1_valid;
        s2_exp   = s1_exp;
        s2_name  = s1_name;
        s1_valid = valid;
        s1_data  = d;
        s1_tx    = tx;
        s1_rx    = rx;
        s1_exp   = e;
        s1_name  = name;
        data_in  = valid ? d : '0;
        itxen    = valid && tx;
    endtask

    task automatic wait_link(input string name);
        int cycles;
        cycles = 0;
        while (!tx_transfer_en && cycles < LINK_BOUND) begin
            @(negedge clk);
            cycles++;
        end
        if (!tx_transfer_en) begin
            error_count++;
            $display("%s: link did not come up within %0d cycles", name, LINK_BOUND);
        end
        check_value({name, " rx_transfer_en"}, 1, rx_transfer_en);
        check_value({name, " fs_mac_rdy"}, mac_rdy, fs_mac_rdy);
    endtask

    task automatic random_run(input string tag);
        aib_pkg::word_t w;
        for (int i = 0; i < N_RAND; i++) begin
            random_word(w);
            data_step(1'b1, w, 1'b1, aib_pkg::RXEN_SYNC, w, $sformatf("%s %0d", tag, i));
        end
        repeat (2) data_step(1'b0, '0, 1'b0, aib_pkg::RXEN_SYNC, '0, "idle");   // drain
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin : main
        int base;
        int cycles;
        rst_n         = 1'b0;
        data_in       = '0;
        itxen         = 1'b0;
        irxen         = aib_pkg::RXEN_SYNC;
        config_done   = 1'b1;
        tx_lock_req   = 1'b1;
        rx_lock_req   = 1'b1;
        adapter_rstn  = 1'b1;
        mac_rdy       = 1'b1;
        external_cntl = '0;
        $readmemh("tb/aib_testdata.hex", tdata);
        if ($isunknown(tdata[0]) || tdata[0] == 0) begin
            error_count++;
            $display("testdata file is missing or holds no vectors");
        end
        n_vec  = $isunknown(tdata[0]) ? 0 : int'(tdata[0]);
        n_user = $isunknown(tdata[1]) ? 0 : int'(tdata[1]);
        wd_ns  = longint'(n_vec + 2 * N_RAND + (3 * n_user + 7) * FRAME + 2 * LINK_BOUND + 16)
                 * CLK_PERIOD * 2;

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("reset tx_transfer_en", 0, tx_transfer_en);
        check_value("reset rx_transfer_en", 0, rx_transfer_en);
        check_value("reset fs_mac_rdy", 0, fs_mac_rdy);
        check_value("reset pad_tx", 0, pad_loop);
        check_value("reset ns_sr_load", 0, sr_load_loop);
        check_value("reset ns_sr_data", 0, sr_data_loop);
        rst_n = 1'b1;

        wait_link("link-up");

        // file vectors followed by lfsr words
        for (int i = 0; i < n_vec; i++) begin
            base = 2 + 3 * i;
            data_step(1'b1, tdata[base], tdata[base+1][3], tdata[base+1][2:0], tdata[base+2],
                      $sformatf("vector %0d", i));
        end
        random_run("lfsr word");

        base = 2 + 3 * n_vec;   // user patterns follow the vectors
        for (int i = 0; i < n_user; i++) begin
            @(negedge clk);
            external_cntl = tdata[base+i][aib_pkg::USER_BITS-1:0];
            repeat (3 * FRAME) @(negedge clk);
            check_value($sformatf("user pattern %0d", i), external_cntl, sr_tomac.user);
        end
        check_value("user bits tx_transfer_en", 1, tx_transfer_en);

        // drop config_done long enough for the far side to see it too
        @(negedge clk);
        config_done = 1'b0;
        mac_rdy     = 1'b0;   // far side must come back not ready
        cycles      = 0;
        while ((tx_transfer_en || rx_transfer_en) && cycles <= FRAME) begin
            @(negedge clk);
            cycles++;
        end
        check_value("link drop enables", 0, {tx_transfer_en, rx_transfer_en});
        repeat (3 * FRAME) @(negedge clk);
        check_value("link drop far config_done", 0, sr_tomac.config_done);
        check_value("link drop tx_transfer_en", 0, tx_transfer_en);
        config_done = 1'b1;
        wait_link("relink");
        random_run("relink word");

        // far-side mac ready rises again while linked
        mac_rdy = 1'b1;
        repeat (3 * FRAME) @(negedge clk);
        check_value("relink fs_mac_rdy", 1, fs_mac_rdy);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (wd_ns > 0);
        #(wd_ns);
        $display("timeout: link-up or test sequence did not finish after %0d ns", wd_ns);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("sim failed");
        $finish;
    end

endmodule

//--- hdl/aib_channel_top.sv
`timescale 1ns/1ps

module aib_channel_top (
    input  logic                            m_ns_fwd_clk,
    input  logic                            rst_n,
    // user data
    input  aib_pkg::word_t                  data_in,
    input  logic                            itxen,
    input  logic [2:0]                      irxen,
    output aib_pkg::word_t                  data_out,
    // local control levels
    input  logic                            config_done,
    input  logic                            tx_dcc_dll_lock_req,
    input  logic                            rx_dcc_dll_lock_req,
    input  logic                            ns_adapter_rstn,
    input  logic                            ns_mac_rdy,
    input  logic [aib_pkg::USER_BITS-1:0]   external_cntl,
    // far-side pins
    output aib_pkg::pad_word_t              pad_tx,
    input  aib_pkg::pad_word_t              pad_rx,
    output logic                            ns_sr_data,
    output logic                            ns_sr_load,
    input  logic                            fs_sr_data,
    input  logic                            fs_sr_load,
    // status
    output logic                            tx_transfer_en,
    output logic                            rx_transfer_en,
    output logic                            fs_mac_rdy,
    output aib_pkg::sr_word_t               sr_tomac
);

    aib_pkg::sr_word_t ns_word;   // local sideband word
    logic              frame_valid;

    assign ns_word = '{
        mac_rdy:      ns_mac_rdy,
        adapter_rstn: ns_adapter_rstn,
        config_done:  config_done,
        tx_lock_req:  tx_dcc_dll_lock_req,
        rx_lock_req:  rx_dcc_dll_lock_req,
        user:         external_cntl
    };

    // ==================================================
    // data path
    // ==================================================
    aib_tx_split u_tx_split (
        .m_ns_fwd_clk   (m_ns_fwd_clk),
        .rst_n          (rst_n),
        .data_in        (data_in),
        .itxen          (itxen),
        .tx_transfer_en (tx_transfer_en),
        .pad_tx         (pad_tx)
    );

    aib_rx_merge u_rx_merge (
        .m_ns_fwd_clk   (m_ns_fwd_clk),
        .rst_n          (rst_n),
        .pad_rx         (pad_rx),
        .irxen          (irxen),
        .rx_transfer_en (rx_transfer_en),
        .data_out       (data_out)
    );

    // ==================================================
    // sideband and link control
    // ==================================================
    aib_sr_serializer u_sr_ser (
        .m_ns_fwd_clk (m_ns_fwd_clk),
        .rst_n        (rst_n),
        .sr_word      (ns_word),
        .sr_data      (ns_sr_data),
        .sr_load      (ns_sr_load)
    );

    aib_sr_deserializer u_sr_deser (
        .m_ns_fwd_clk (m_ns_fwd_clk),
        .rst_n        (rst_n),
        .sr_data      (fs_sr_data),
        .sr_load      (fs_sr_load),
        .sr_tomac     (sr_tomac),
        .frame_valid  (frame_valid)
    );

    aib_link_ctrl u_link_ctrl (
        .m_ns_fwd_clk   (m_ns_fwd_clk),
        .rst_n          (rst_n),
        .config_done    (config_done),
        .tx_lock_req    (tx_dcc_dll_lock_req),
        .rx_lock_req    (rx_dcc_dll_lock_req),
        .adapter_rstn   (ns_adapter_rstn),
        .fs_word        (sr_tomac),
        .frame_valid    (frame_valid),
        .tx_transfer_en (tx_transfer_en),
        .rx_transfer_en (rx_transfer_en),
        .fs_mac_rdy     (fs_mac_rdy)
    );

endmodule

//--- hdl/aib_rx_merge.sv
`timescale 1ns/1ps

module aib_rx_merge (
    input  logic               m_ns_fwd_clk,
    input  logic               rst_n,
    input  aib_pkg::pad_word_t pad_rx,           // halves from the far side
    input  logic [2:0]         irxen,            // receive enable code
    input  logic               rx_transfer_en,
    output aib_pkg::word_t     data_out
);

    aib_pkg::word_t merged;
    logic           rx_on;

    // anything other than the sync code blocks the data
    assign rx_on = (irxen == aib_pkg::RXEN_SYNC) && rx_transfer_en;

    // ==================================================
    // re-interleave halves
    // ==================================================
    always_comb begin
        for (int i = 0; i < aib_pkg::DATAWIDTH; i++) begin
            merged[2*i]   = pad_rx.dat0[i];   // even bits
            merged[2*i+1] = pad_rx.dat1[i];   // odd bits
        end
    end

    // output register, forced to zero when receive is off
    always_ff @(posedge m_ns_fwd_clk) begin
        if (!rst_n) begin
            data_out <= '0;
        end else if (rx_on) begin
            data_out <= merged;
        end else begin
            data_out <= '0;
        end
    end

endmodule

//--- hdl/aib_link_ctrl.sv
`timescale 1ns/1ps

module aib_link_ctrl (
    input  logic              m_ns_fwd_clk,
    input  logic              rst_n,
    input  logic              config_done,
    input  logic              tx_lock_req,
    input  logic              rx_lock_req,
    input  logic              adapter_rstn,
    input  aib_pkg::sr_word_t fs_word,       // far-side frame
    input  logic              frame_valid,
    output logic              tx_transfer_en,
    output logic              rx_transfer_en,
    output logic              fs_mac_rdy
);

    aib_pkg::link_state_t           state_q;
    aib_pkg::link_state_t           state_d;
    logic [aib_pkg::CAL_CNT_W-1:0]  cal_cnt;
    logic                           fs_seen;    // sticky, a far-side frame arrived
    logic                           cfg_ok;
    logic                           lock_ok;
    logic                           linked_q;

    assign cfg_ok  = config_done && fs_seen && fs_word.config_done;
    assign lock_ok = cfg_ok && tx_lock_req && rx_lock_req && adapter_rstn
                     && fs_word.tx_lock_req && fs_word.rx_lock_req && fs_word.adapter_rstn;

    // ==================================================
    // next state
    // ==================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            aib_pkg::RESET:    state_d = aib_pkg::WAIT_CFG;
            aib_pkg::WAIT_CFG: if (cfg_ok) state_d = aib_pkg::CALIB;
            aib_pkg::CALIB: begin
                if (!lock_ok) begin
                    state_d = aib_pkg::WAIT_CFG;
                end else if (cal_cnt == aib_pkg::CAL_LAST) begin
                    state_d = aib_pkg::LINKED;
                end
            end
            aib_pkg::LINKED:   if (!lock_ok) state_d = aib_pkg::WAIT_CFG;
            default:           state_d = aib_pkg::RESET;
        endcase
    end

    always_ff @(posedge m_ns_fwd_clk) begin
        if (!rst_n) begin
            state_q  <= aib_pkg::RESET;
            cal_cnt  <= '0;
            fs_seen  <= 1'b0;
            linked_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            linked_q <= (state_d == aib_pkg::LINKED);
            if (frame_valid) fs_seen <= 1'b1;
            // counts only consecutive good cycles inside CALIB
            if (state_q == aib_pkg::CALIB && lock_ok) begin
                cal_cnt <= cal_cnt + 1'b1;
            end else begin
                cal_cnt <= '0;
            end
        end
    end

    assign tx_transfer_en = linked_q;
    assign rx_transfer_en = linked_q;
    assign fs_mac_rdy     = linked_q && fs_word.mac_rdy;   // far-side mac ready once linked

    a_en_only_linked: assert property (
        @(posedge m_ns_fwd_clk) disable iff (!rst_n)
        (tx_transfer_en || rx_transfer_en) |-> (state_q == aib_pkg::LINKED)
    ) else $error("transfer enable high outside LINKED");

    // enable is a cycle behind the lock request it was granted on
    a_en_needs_lock: assert property (
        @(posedge m_ns_fwd_clk) disable iff (!rst_n)
        tx_transfer_en |-> $past(tx_lock_req)
    ) else $error("tx_transfer_en without local lock request");

endmodule

//--- hdl/aib_sr_deserializer.sv
`timescale 1ns/1ps

module aib_sr_deserializer (
    input  logic              m_ns_fwd_clk,
    input  logic              rst_n,
    input  logic              sr_data,      // far-side serial bit
    input  logic              sr_load,      // far-side frame strobe
    output aib_pkg::sr_word_t sr_tomac,     // last complete far-side frame
    output logic              frame_valid
);

    logic [aib_pkg::SR_LEN-1:0] shift_q;
    logic                       load_seen;   // first strobe only starts framing

    // free running shift, strobe alone marks frame edges
    always_ff @(posedge m_ns_fwd_clk) begin
        shift_q <= {shift_q[aib_pkg::SR_LEN-2:0], sr_data};
    end

    // ==================================================
    // frame capture
    // ==================================================
    always_ff @(posedge m_ns_fwd_clk) begin
        if (!rst_n) begin
            sr_tomac    <= '0;
            frame_valid <= 1'b0;
            load_seen   <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (sr_load) begin
                load_seen <= 1'b1;
                // bits before the first strobe are not a frame
                if (load_seen) begin
                    sr_tomac    <= aib_pkg::sr_word_t'(shift_q);
                    frame_valid <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/aib_sr_serializer.sv
`timescale 1ns/1ps

module aib_sr_serializer (
    input  logic              m_ns_fwd_clk,
    input  logic              rst_n,
    input  aib_pkg::sr_word_t sr_word,   // local control bits, sampled at frame start
    output logic              sr_data,
    output logic              sr_load
);

    logic [aib_pkg::SR_CNT_W-1:0] bit_cnt;   // 0 .. SR_LEN
    logic [aib_pkg::SR_LEN-1:0]   shift_q;
    logic                         frame_start;

    assign frame_start = (bit_cnt == '0);

    // ==================================================
    // frame counter
    // ==================================================
    always_ff @(posedge m_ns_fwd_clk) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (bit_cnt == aib_pkg::SR_LAST) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // shift register holds the word being sent
    always_ff @(posedge m_ns_fwd_clk) begin
        if (frame_start) begin
            shift_q <= sr_word;
        end else begin
            shift_q <= {shift_q[aib_pkg::SR_LEN-2:0], 1'b0};   // msb first
        end
    end

    // ==================================================
    // pin outputs
    // ==================================================
    always_ff @(posedge m_ns_fwd_clk) begin
        if (!rst_n) begin
            sr_load <= 1'b0;
            sr_data <= 1'b0;
        end else begin
            sr_load <= frame_start;
            // data line rests low during the load cycle
            sr_data <= frame_start ? 1'b0 : shift_q[aib_pkg::SR_LEN-1];
        end
    end

    // exactly one load strobe per SR_LEN+1 cycles
    a_load_period: assert property (
        @(posedge m_ns_fwd_clk) disable iff (!rst_n)
        sr_load |=> !sr_load [*aib_pkg::SR_LEN] ##1 sr_load
    ) else $error("sideband load strobe out of period");

endmodule

//--- hdl/aib_tx_split.sv
`timescale 1ns/1ps

module aib_tx_split (
    input  logic               m_ns_fwd_clk,
    input  logic               rst_n,
    input  aib_pkg::word_t     data_in,
    input  logic               itxen,           // data tx enable
    input  logic               tx_transfer_en,  // from link controller
    output aib_pkg::pad_word_t pad_tx
);

    aib_pkg::pad_word_t split;

    // even bits go to half 0, odd bits to half 1
    always_comb begin
        for (int i = 0; i < aib_pkg::DATAWIDTH; i++) begin
            split.dat0[i] = data_in[2*i];
            split.dat1[i] = data_in[2*i+1];
        end
    end

    // ==================================================
    // pad register
    // ==================================================
    // idle bus is all zero, far side never sees stale data
    always_ff @(posedge m_ns_fwd_clk) begin
        if (!rst_n) begin
            pad_tx <= '0;
        end else if (itxen && tx_transfer_en) begin
            pad_tx <= split;
        end else begin
            pad_tx <= '0;
        end
    end

    // a cycle without enable leaves the pads idle on the next one
    a_idle_after_disable: assert property (
        @(posedge m_ns_fwd_clk) disable iff (!rst_n)
        !(itxen && tx_transfer_en) |=> (pad_tx == '0)
    ) else $error("pad_tx not idle after a cycle without tx enable");

endmodule

//--- hdl/aib_pkg.sv
package aib_pkg;

    // ==================================================
    // data path widths
    // ==================================================
    localparam int DATAWIDTH = 20;   // one pad half

    typedef logic [DATAWIDTH-1:0]   half_t;
    typedef logic [2*DATAWIDTH-1:0] word_t;   // bit 2i -> half 0, bit 2i+1 -> half 1

    // the two halves as they cross the pads
    typedef struct packed {
        half_t dat0;
        half_t dat1;
    } pad_word_t;

    // receive enable code that lets data through
    localparam logic [2:0] RXEN_SYNC = 3'b001;

    // ==================================================
    // sideband shift register
    // ==================================================
    localparam int USER_BITS = 11;

    typedef struct packed {
        logic                 mac_rdy;
        logic                 adapter_rstn;
        logic                 config_done;
        logic                 tx_lock_req;
        logic                 rx_lock_req;
        logic [USER_BITS-1:0] user;   // free user control bits
    } sr_word_t;

    localparam int SR_LEN   = $bits(sr_word_t);
    localparam int SR_CNT_W = $clog2(SR_LEN + 1);
    localparam logic [SR_CNT_W-1:0] SR_LAST = SR_CNT_W'(SR_LEN);   // frame is SR_LEN+1 cycles

    // ==================================================
    // link-up control
    // ==================================================
    localparam int CAL_CYCLES = 8;   // stable lock agreement needed
    localparam int CAL_CNT_W  = $clog2(CAL_CYCLES + 1);
    localparam logic [CAL_CNT_W-1:0] CAL_LAST = CAL_CNT_W'(CAL_CYCLES - 1);

    typedef enum logic [1:0] {
        RESET    = 2'd0,
        WAIT_CFG = 2'd1,
        CALIB    = 2'd2,
        LINKED   = 2'd3
    } link_state_t;

endpackage
